/* bench/tb_cn_node.sv */
`timescale 1ns/1ps
`include "cn_node_defs.svh"

module tb_cn_node import cn_node_pkg::*;;

    localparam logic [31:0] SEED     = 32'h23a0ee50;
    localparam int          OP_CYC   = 16;              // worst case cycles of one axi access
    localparam int          N_RAND   = 40;              // random write and read pairs
    localparam int          TICK_MAX = 4 * `CN_STEPS;   // tick length at div 3
    localparam int          T1       = 8 * OP_CYC + 12;
    localparam int          T2       = (2 * N_RAND + 11) * OP_CYC;
    localparam int          T3       = 12 + 3 * TICK_MAX + OP_CYC;
    localparam int          T4       = 14 * OP_CYC + 5 * TICK_MAX;
    localparam int          T5       = 9 * OP_CYC + 4 * TICK_MAX;
    localparam int          LIMIT    = (T1 + T2 + T3 + T4 + T5) * 3 / 2;

    // izhikevich coefficients in q16.16, rounded
    localparam longint Q_004 = 2621;   // 0.04
    localparam longint Q_B   = 13107;  // b = 0.2
    localparam longint Q_A   = 1311;   // a = 0.02

    logic      ep50trig;
    logic      reset_global;
    axil_req_t req;
    axil_rsp_t rsp;
    logic [2:0] spike_in;
    logic      o_spike;
    logic      spike_en;  // random presynaptic spikes on

    // reference model state
    logic [31:0]        m_reg [6];   // ltp ltd p_delta gain div drive
    logic [31:0]        m_cyc;
    logic [6:0]         m_stepcnt;
    logic [7:0]         m_prehist [3];
    logic [7:0]         m_posthist [3];
    logic               m_prelat [3];
    logic               m_postlat [3];
    logic [31:0]        m_w [3];
    logic signed [31:0] m_cur [3];
    logic [31:0]        m_each [3];
    logic signed [31:0] m_v;
    logic signed [31:0] m_u;
    logic signed [31:0] m_ilat;
    logic               m_spike;
    logic [31:0]        m_win;
    logic [31:0]        m_count;
    logic [31:0]        obs_win;     // pulses seen on o_spike, same window rule
    logic [31:0]        obs_count;
    int                 m_ticks;
    int                 pulse_total;
    int                 cycles;
    int                 test_errs;
    int                 total_errs;
    int                 n_tests;
    int                 n_failed;

    cn_node_top UUT (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_axil       (req),
        .o_axil       (rsp),
        .i_spike_in   (spike_in),
        .o_spike      (o_spike)
    );

    always #20 ep50trig = ~ep50trig;  // 40 ns period

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    function automatic logic is_writable(input logic [31:0] addr);
        return addr inside {`CN_A_LTP, `CN_A_LTD, `CN_A_PDELTA, `CN_A_GAIN, `CN_A_DIV, `CN_A_DRIVE};
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // what a read at this moment must return
    task automatic expect_read(input logic [31:0] addr, output logic [31:0] data,
                               output logic [1:0] resp);
        resp = `CN_RESP_OKAY;
        data = '0;
        if (is_writable(addr)) begin
            data = m_reg[addr[4:2]];
        end else if (addr == `CN_A_VMEM) begin
            data = m_v;
        end else if (addr == `CN_A_SCOUNT) begin
            data = m_count;
        end else begin
            resp = `CN_RESP_SLVERR;
        end
    endtask

    task automatic neuron_step(input logic signed [31:0] v_in, input logic signed [31:0] u_in,
                               input logic signed [31:0] i_in,
                               output logic signed [31:0] v_out,
                               output logic signed [31:0] u_out, output logic fired);
        longint v;
        longint u;
        longint cur;
        longint dv;
        longint du;
        longint v_next;
        longint u_next;
        v      = v_in;
        u      = u_in;
        cur    = i_in;
        dv     = ((((v * v) >>> 16) * Q_004) >>> 16) + 5 * v + (longint'(140) <<< 16) - u + cur;
        v_next = v + (dv >>> 3);                            // dt of 1/8
        du     = ((((v * Q_B) >>> 16) - u) * Q_A) >>> 16;   // a (b v - u)
        u_next = u + (du >>> 3);
        fired  = (v_next >= longint'(`CN_V_PEAK));
        if (fired) begin
            v_out = `CN_V_RESET;
            u_out = u_next[31:0] + `CN_U_JUMP;
        end else begin
            v_out = v_next[31:0];
            u_out = u_next[31:0];
        end
    endtask

    // cycle model of the node, sampled on the same edge as the dut
    always @(posedge ep50trig or posedge reset_global) begin : model
        logic        step;
        logic        tick;
        logic        old_spike;
        logic        pre_now;
        logic        post_now;
        logic        fire;
        logic [31:0] isum;
        logic [31:0] kick;
        longint      wsum;
        logic signed [31:0] vn;
        logic signed [31:0] un;
        if (reset_global) begin
            m_cyc     = '0;
            m_stepcnt = '0;
            m_v       = `CN_V_REST;
            m_u       = '0;
            m_ilat    = '0;
            m_spike   = 1'b0;
            m_win     = '0;
            m_count   = '0;
            obs_win   = '0;
            obs_count = '0;
            for (int g = 0; g < 3; g++) begin
                m_prehist[g]  = '0;
                m_posthist[g] = '0;
                m_prelat[g]   = 1'b0;
                m_postlat[g]  = 1'b0;
                m_w[g]        = '0;
                m_cur[g]      = '0;
                m_each[g]     = '0;
            end
        end else begin
            fire      = 1'b0;
            step      = (m_cyc >= m_reg[4]);
            tick      = step && (m_stepcnt == 7'(`CN_STEPS - 1));
            old_spike = m_spike;                                     // post spike seen this edge
            isum      = m_each[0] + m_each[1] + m_each[2] + m_reg[5];  // before the synapses move
            for (int g = 0; g < 3; g++) begin
                pre_now  = m_prelat[g] | spike_in[g];
                post_now = m_postlat[g] | old_spike;
                if (step) begin
                    if (pre_now && m_posthist[g] != 0) begin  // post before pre, potentiate
                        wsum   = longint'(m_w[g]) + longint'(m_reg[0]);
                        m_w[g] = (wsum > 64'hFFFF_FFFF) ? 32'hFFFF_FFFF : wsum[31:0];
                    end
                    if (post_now && m_prehist[g] != 0) begin  // pre before post, depress
                        m_w[g] = (m_w[g] > m_reg[1]) ? m_w[g] - m_reg[1] : 32'd0;
                    end
                    kick          = pre_now ? m_w[g] + m_reg[2] : 32'd0;
                    m_cur[g]      = (m_cur[g] >>> 1) + $signed(kick);
                    m_each[g]     = m_cur[g] * m_reg[3];   // low word of current times gain
                    m_prehist[g]  = {m_prehist[g][6:0], pre_now};
                    m_posthist[g] = {m_posthist[g][6:0], post_now};
                    m_prelat[g]   = 1'b0;
                    m_postlat[g]  = 1'b0;
                end else begin
                    m_prelat[g]  = pre_now;  // held to the next step
                    m_postlat[g] = post_now;
                end
            end
            if (step) begin
                neuron_step(m_v, m_u, m_ilat, vn, un, fire);  // drive latched last step
                m_v    = vn;
                m_u    = un;
                m_ilat = isum;
            end
            m_spike = step && fire;
            if (tick) begin
                m_count   = m_win;
                m_win     = {31'd0, old_spike};  // spike on the tick opens the new window
                obs_count = obs_win;
                obs_win   = {31'd0, o_spike};
                m_ticks++;
            end else begin
                m_win   = m_win + old_spike;
                obs_win = obs_win + o_spike;
            end
            if (o_spike) pulse_total++;
            if (step) begin
                m_cyc     = '0;
                m_stepcnt = m_stepcnt + 1'b1;
            end else begin
                m_cyc = m_cyc + 1;
            end
        end
    end

    // o_spike must follow the model every cycle
    always @(negedge ep50trig) begin
        if (!reset_global) check_val("o_spike", {31'd0, o_spike}, {31'd0, m_spike});
    end

    always @(posedge ep50trig) begin
        if (spike_en) begin
            spike_in <= {($urandom % 16) == 0, ($urandom % 16) == 0, ($urandom % 16) == 0};
        end else begin
            spike_in <= 3'b000;
        end
    end

    always @(posedge ep50trig) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: no finish within %0d clock cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge ep50trig);
        reset_global <= 1'b1;
        m_reg[0]     <= '0;
        m_reg[1]     <= '0;
        m_reg[2]     <= '0;
        m_reg[3]     <= `CN_GAIN_RST;
        m_reg[4]     <= `CN_DIV_RST;
        m_reg[5]     <= '0;
        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [1:0] exp_resp;
        int         stall;
        @(posedge ep50trig);
        req.awaddr  <= addr;
        req.wdata   <= data;
        req.wstrb   <= strb;
        req.awvalid <= 1'b1;
        req.wvalid  <= 1'b1;
        req.bready  <= 1'b0;
        do @(negedge ep50trig); while (!(rsp.awready && rsp.wready));
        exp_resp = is_writable(addr) ? `CN_RESP_OKAY : `CN_RESP_SLVERR;
        @(posedge ep50trig);  // aw and w taken on this edge
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        if (is_writable(addr)) m_reg[addr[4:2]] <= apply_strobes(m_reg[addr[4:2]], data, strb);
        do @(negedge ep50trig); while (!rsp.bvalid);
        check_val("awready", {31'd0, rsp.awready}, 32'd0);  // pending response blocks writes
        check_val("wready", {31'd0, rsp.wready}, 32'd0);
        stall = $urandom % 4;
        repeat (stall) begin
            @(negedge ep50trig);
            check_val("bvalid", {31'd0, rsp.bvalid}, 32'd1);  // held while bready stalls
        end
        check_val("bresp", {30'd0, rsp.bresp}, {30'd0, exp_resp});
        @(posedge ep50trig);
        req.bready <= 1'b1;
        @(posedge ep50trig);
        req.bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        logic [31:0] first;
        int          stall;
        @(posedge ep50trig);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        req.rready  <= 1'b0;
        do @(negedge ep50trig); while (!rsp.arready);
        expect_read(addr, exp_data, exp_resp);  // state the dut samples on the accept edge
        @(posedge ep50trig);
        req.arvalid <= 1'b0;
        do @(negedge ep50trig); while (!rsp.rvalid);
        check_val("arready", {31'd0, rsp.arready}, 32'd0);  // held rvalid blocks reads
        first = rsp.rdata;
        stall = $urandom % 4;
        repeat (stall) begin
            @(negedge ep50trig);
            check_val("rvalid", {31'd0, rsp.rvalid}, 32'd1);
            check_val("rdata held", rsp.rdata, first);
        end
        check_val("rresp", {30'd0, rsp.rresp}, {30'd0, exp_resp});
        if (exp_resp == `CN_RESP_OKAY) check_val($sformatf("rdata@%h", addr), rsp.rdata, exp_data);
        data = rsp.rdata;
        @(posedge ep50trig);
        req.rready <= 1'b1;
        @(posedge ep50trig);
        req.rready <= 1'b0;
    endtask

    task automatic wait_ticks(input int n);
        int target;
        target = m_ticks + n;
        while (m_ticks < target) @(negedge ep50trig);
    endtask

    task automatic end_test(input string name);
        $display("test %-14s %s, %0d errors", name, (test_errs == 0) ? "ok" : "bad", test_errs);
        n_tests++;
        if (test_errs != 0) n_failed++;
        total_errs += test_errs;
        test_errs = 0;
    endtask

    function automatic logic [31:0] pick_addr();
        int r;
        r = $urandom % 10;
        if (r < 8) return 32'(r * 4);
        if (r == 8) return 32'h20 + 32'(4 * ($urandom % 32));  // hole above the map
        return 32'($urandom % 32) | 32'd1;                      // unaligned
    endfunction

    initial begin
        logic [31:0] addr;
        logic [31:0] rd;
        int          snap;
        void'($urandom(SEED));
        ep50trig     = 1'b0;
        reset_global <= 1'b1;
        req          <= '0;
        spike_in     <= 3'b000;
        spike_en     = 1'b0;
        cycles       = 0;
        m_ticks      = 0;
        pulse_total  = 0;
        test_errs    = 0;
        total_errs   = 0;
        n_tests      = 0;
        n_failed     = 0;
        apply_reset();

        @(negedge ep50trig);
        check_val("awready", {31'd0, rsp.awready}, 32'd1);  // all channels open after reset
        check_val("wready", {31'd0, rsp.wready}, 32'd1);
        check_val("arready", {31'd0, rsp.arready}, 32'd1);
        check_val("bvalid", {31'd0, rsp.bvalid}, 32'd0);
        check_val("rvalid", {31'd0, rsp.rvalid}, 32'd0);
        for (int a = 0; a < 8; a++) read_reg(32'(a * 4), rd);  // gain 1, div 2, v rest, count 0
        end_test("reset values");

        repeat (N_RAND) begin
            addr = pick_addr();
            write_reg(addr, $urandom, 4'($urandom % 16));
            read_reg(addr, rd);
        end
        write_reg(`CN_A_VMEM, 32'h1234_5678, 4'hF);    // read only, slverr
        write_reg(`CN_A_SCOUNT, 32'h0000_00FF, 4'hF);
        write_reg(32'h0000_0040, 32'hDEAD_BEEF, 4'hF);
        for (int a = 0; a < 6; a++) read_reg(32'(a * 4), rd);  // refused writes left no trace
        read_reg(32'h0000_0040, rd);
        read_reg(32'h0000_0022, rd);
        end_test("random access");

        apply_reset();
        snap = pulse_total;
        wait_ticks(2);
        check_val("quiet pulses", 32'(pulse_total - snap), 32'd0);
        read_reg(`CN_A_SCOUNT, rd);
        check_val("quiet scount", rd, 32'd0);
        end_test("quiet");

        write_reg(`CN_A_LTP, $urandom % 32'h1000, 4'hF);
        write_reg(`CN_A_LTD, $urandom % 32'h1000, 4'hF);
        write_reg(`CN_A_PDELTA, $urandom % 32'h2_0000, 4'hF);
        write_reg(`CN_A_GAIN, 32'd1 + $urandom % 3, 4'hF);
        write_reg(`CN_A_DIV, $urandom % 4, 4'hF);
        write_reg(`CN_A_DRIVE, $urandom % 32'h8_0000, 4'hF);
        spike_en = 1'b1;
        repeat (4) begin
            wait_ticks(1);
            read_reg(`CN_A_SCOUNT, rd);
            read_reg(`CN_A_VMEM, rd);
        end
        spike_en = 1'b0;
        end_test("random spikes");

        write_reg(`CN_A_LTP, 32'd0, 4'hF);
        write_reg(`CN_A_LTD, 32'd0, 4'hF);
        write_reg(`CN_A_PDELTA, 32'd0, 4'hF);
        write_reg(`CN_A_GAIN, 32'd1, 4'hF);
        write_reg(`CN_A_DIV, 32'd1, 4'hF);
        write_reg(`CN_A_DRIVE, 32'h0032_0000, 4'hF);  // 50 in q16.16
        snap = pulse_total;
        repeat (3) begin
            wait_ticks(1);
            check_val("pulses per tick", obs_count, m_count);
            read_reg(`CN_A_SCOUNT, rd);
            check_val("scount vs pulses", rd, obs_count);
        end
        if (pulse_total == snap) begin
            $display("the neuron never fired under a large drive");
            test_errs++;
        end
        end_test("large drive");

        $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, total_errs);
        if (total_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* cn_node_top.f */
+incdir+common
common/cn_node_pkg.sv
rtl/param_regs.sv
rtl/tick_gen.sv
synapse/synapse.sv
neuron/izneuron.sv
rtl/spike_counter.sv
rtl/cn_node_top.sv
bench/tb_cn_node.sv

/* common/cn_node_defs.svh */
`ifndef CN_NODE_DEFS_SVH
`define CN_NODE_DEFS_SVH

`define CN_DW          32              // axi data and parameter width

// register map, byte addresses
`define CN_A_LTP       32'h0000_0000
`define CN_A_LTD       32'h0000_0004
`define CN_A_PDELTA    32'h0000_0008
`define CN_A_GAIN      32'h0000_000C
`define CN_A_DIV       32'h0000_0010
`define CN_A_DRIVE     32'h0000_0014
`define CN_A_VMEM      32'h0000_0018   // read only
`define CN_A_SCOUNT    32'h0000_001C   // read only

`define CN_GAIN_RST    32'd1           // unity synaptic gain
`define CN_DIV_RST     32'd2           // step every 3 clocks after reset
`define CN_RESP_OKAY   2'b00
`define CN_RESP_SLVERR 2'b10

`define CN_STEPS       128             // neuron steps per sim tick

// neuron constants, signed q16.16
`define CN_V_REST      32'shFFBF_0000  // -65 mV
`define CN_V_PEAK      32'sh001E_0000  // +30 mV
`define CN_V_RESET     32'shFFBF_0000  // c = -65
`define CN_U_JUMP      32'sh0008_0000  // d = 8

`endif

/* common/cn_node_pkg.sv */
`include "cn_node_defs.svh"

package cn_node_pkg;

    // learning and gain words shared by all synapses
    typedef struct packed {
        logic [`CN_DW-1:0] ltp;      // potentiation step
        logic [`CN_DW-1:0] ltd;      // depression step
        logic [`CN_DW-1:0] p_delta;  // fixed current kick per pre spike
        logic [`CN_DW-1:0] gain;     // current multiplier
    } syn_params_t;

    typedef struct packed {
        syn_params_t       syn;
        logic [`CN_DW-1:0] drive;    // extra drive current, q16.16
        logic [`CN_DW-1:0] div;      // clocks per step minus one
    } node_params_t;

    // host to dut
    typedef struct packed {
        logic [`CN_DW-1:0]   awaddr;
        logic                awvalid;
        logic [`CN_DW-1:0]   wdata;
        logic [`CN_DW/8-1:0] wstrb;
        logic                wvalid;
        logic                bready;
        logic [`CN_DW-1:0]   araddr;
        logic                arvalid;
        logic                rready;
    } axil_req_t;

    // dut to host
    typedef struct packed {
        logic              awready;
        logic              wready;
        logic [1:0]        bresp;
        logic              bvalid;
        logic              arready;
        logic [`CN_DW-1:0] rdata;
        logic [1:0]        rresp;
        logic              rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic step;  // one neuron update
        logic tick;  // end of sim tick, always with step
    } tick_t;

endpackage

/* neuron/izneuron.sv */
`timescale 1ns/1ps
`include "cn_node_defs.svh"

module izneuron (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  i_step,
    input  logic [2:0][`CN_DW-1:0] i_each_i,  // synapse currents
    input  logic [`CN_DW-1:0]     i_drive,    // host extra drive
    output logic [`CN_DW-1:0]     o_v,        // membrane potential, q16.16
    output logic                  o_spike
);

    // q16.16 coefficients
    localparam logic signed [63:0] K_QUAD = 64'sd2621;   // 0.04
    localparam logic signed [63:0] K_LIN  = 64'sd5;
    localparam logic signed [63:0] K_BIAS = 64'sd140 <<< 16;
    localparam logic signed [63:0] K_B    = 64'sd13107;  // b = 0.2
    localparam logic signed [63:0] K_A    = 64'sd1311;   // a = 0.02

    logic signed [`CN_DW-1:0] v_q;
    logic signed [`CN_DW-1:0] u_q;
    logic signed [`CN_DW-1:0] i_lat;  // drive latched on the previous step
    logic [`CN_DW-1:0]        i_sum;
    logic signed [63:0]       v_w;
    logic signed [63:0]       u_w;
    logic signed [63:0]       i_w;
    logic signed [63:0]       vsq;
    logic signed [63:0]       dv;
    logic signed [63:0]       bv;
    logic signed [63:0]       du;
    logic signed [63:0]       v_new;
    logic signed [63:0]       u_new;
    logic                     fire;

    assign i_sum = i_each_i[0] + i_each_i[1] + i_each_i[2] + i_drive;

    always_comb begin
        v_w   = v_q;  // sign extend
        u_w   = u_q;
        i_w   = i_lat;
        vsq   = (v_w * v_w) >>> 16;
        dv    = ((vsq * K_QUAD) >>> 16) + v_w * K_LIN + K_BIAS - u_w + i_w;
        v_new = v_w + (dv >>> 3);  // dt = 1/8
        bv    = (v_w * K_B) >>> 16;
        du    = ((bv - u_w) * K_A) >>> 16;
        u_new = u_w + (du >>> 3);
        fire  = (v_new >= `CN_V_PEAK);
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            v_q     <= `CN_V_REST;
            u_q     <= '0;
            i_lat   <= '0;
            o_spike <= 1'b0;
        end else begin
            o_spike <= i_step && fire;  // one cycle, right after the firing step
            if (i_step) begin
                i_lat <= i_sum;  // used on the next step
                if (fire) begin
                    v_q <= `CN_V_RESET;
                    u_q <= u_new[`CN_DW-1:0] + `CN_U_JUMP;
                end else begin
                    v_q <= v_new[`CN_DW-1:0];
                    u_q <= u_new[`CN_DW-1:0];
                end
            end
        end
    end

    assign o_v = v_q;

    // the reset to CN_V_RESET keeps spikes from running back to back
    a_spike_pulse: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike |=> !o_spike);

endmodule

/* rtl/cn_node_top.sv */
`timescale 1ns/1ps
`include "cn_node_defs.svh"

module cn_node_top import cn_node_pkg::*; (
    input  logic      ep50trig,
    input  logic      reset_global,
    input  axil_req_t i_axil,
    output axil_rsp_t o_axil,
    input  logic [2:0] i_spike_in,  // presynaptic spikes
    output logic      o_spike       // neuron spike, also fed back to the synapses
);

    node_params_t               params;
    tick_t                      tick;
    logic [2:0][`CN_DW-1:0]     each_i;   // gained synapse currents
    logic [`CN_DW-1:0]          v_mem;
    logic [`CN_DW-1:0]          scount;

    param_regs u_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_axil       (i_axil),
        .o_axil       (o_axil),
        .i_vmem       (v_mem),
        .i_scount     (scount),
        .o_params     (params)
    );

    tick_gen u_tick (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_div        (params.div),
        .o_tick       (tick)
    );

    for (genvar g = 0; g < 3; g++) begin : g_syn
        synapse u_syn (
            .ep50trig     (ep50trig),
            .reset_global (reset_global),
            .i_step       (tick.step),
            .i_spike_pre  (i_spike_in[g]),
            .i_spike_post (o_spike),       // stdp feedback
            .i_params     (params.syn),    // shared learning and gain
            .o_each_i     (each_i[g])
        );
    end

    izneuron u_neuron (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_step       (tick.step),
        .i_each_i     (each_i),
        .i_drive      (params.drive),
        .o_v          (v_mem),
        .o_spike      (o_spike)
    );

    spike_counter u_count (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (tick.tick),
        .i_spike      (o_spike),
        .o_count      (scount)
    );

endmodule

/* rtl/param_regs.sv */
`timescale 1ns/1ps
`include "cn_node_defs.svh"

module param_regs import cn_node_pkg::*; (
    input  logic              ep50trig,
    input  logic              reset_global,
    input  axil_req_t         i_axil,
    output axil_rsp_t         o_axil,
    input  logic [`CN_DW-1:0] i_vmem,    // membrane potential
    input  logic [`CN_DW-1:0] i_scount,  // last complete spike count
    output node_params_t      o_params
);

    node_params_t      params;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              rvalid;
    logic [1:0]        rresp;
    logic [`CN_DW-1:0] rdata;
    logic [`CN_DW-1:0] rd_word;
    logic              rd_err;
    logic              wr_go;
    logic              rd_go;

    // merge the strobed bytes of a write into the old word
    function automatic logic [`CN_DW-1:0] merge_strb(input logic [`CN_DW-1:0]   old_w,
                                                     input logic [`CN_DW-1:0]   new_w,
                                                     input logic [`CN_DW/8-1:0] strb);
        logic [`CN_DW-1:0] res;
        res = old_w;
        for (int b = 0; b < `CN_DW/8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wr_go = i_axil.awvalid & i_axil.wvalid & ~bvalid;  // aw and w taken together
    assign rd_go = i_axil.arvalid & ~rvalid;

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (i_axil.araddr)
            `CN_A_LTP:    rd_word = params.syn.ltp;
            `CN_A_LTD:    rd_word = params.syn.ltd;
            `CN_A_PDELTA: rd_word = params.syn.p_delta;
            `CN_A_GAIN:   rd_word = params.syn.gain;
            `CN_A_DIV:    rd_word = params.div;
            `CN_A_DRIVE:  rd_word = params.drive;
            `CN_A_VMEM:   rd_word = i_vmem;
            `CN_A_SCOUNT: rd_word = i_scount;
            default:      rd_err  = 1'b1;  // unmapped
        endcase
    end

    // write channel and register file
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            params          <= '0;
            params.syn.gain <= `CN_GAIN_RST;
            params.div      <= `CN_DIV_RST;
            bvalid          <= 1'b0;
            bresp           <= `CN_RESP_OKAY;
        end else if (wr_go) begin
            bvalid <= 1'b1;
            bresp  <= `CN_RESP_OKAY;
            case (i_axil.awaddr)
                `CN_A_LTP: params.syn.ltp <=
                    merge_strb(params.syn.ltp, i_axil.wdata, i_axil.wstrb);
                `CN_A_LTD: params.syn.ltd <=
                    merge_strb(params.syn.ltd, i_axil.wdata, i_axil.wstrb);
                `CN_A_PDELTA: params.syn.p_delta <=
                    merge_strb(params.syn.p_delta, i_axil.wdata, i_axil.wstrb);
                `CN_A_GAIN: params.syn.gain <=
                    merge_strb(params.syn.gain, i_axil.wdata, i_axil.wstrb);
                `CN_A_DIV:   params.div <= merge_strb(params.div, i_axil.wdata, i_axil.wstrb);
                `CN_A_DRIVE: params.drive <=
                    merge_strb(params.drive, i_axil.wdata, i_axil.wstrb);
                default: bresp <= `CN_RESP_SLVERR;  // status words and holes are not writable
            endcase
        end else if (i_axil.bready) begin
            bvalid <= 1'b0;
        end
    end

    // read channel control
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            rvalid <= 1'b0;
            rresp  <= `CN_RESP_OKAY;
        end else if (rd_go) begin
            rvalid <= 1'b1;
            rresp  <= rd_err ? `CN_RESP_SLVERR : `CN_RESP_OKAY;
        end else if (i_axil.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge ep50trig) begin
        if (rd_go) begin
            rdata <= rd_word;  // sampled at accept, held while rvalid waits
        end
    end

    always_comb begin
        o_axil         = '0;
        o_axil.awready = ~bvalid;  // a pending response stalls the next write
        o_axil.wready  = ~bvalid;
        o_axil.bvalid  = bvalid;
        o_axil.bresp   = bresp;
        o_axil.arready = ~rvalid;
        o_axil.rvalid  = rvalid;
        o_axil.rresp   = rresp;
        o_axil.rdata   = rdata;
    end

    assign o_params = params;

    // host must see the write response until it takes it
    a_bvalid_hold: assert property (@(posedge ep50trig) disable iff (reset_global)
        bvalid && !i_axil.bready |=> bvalid);

endmodule

/* rtl/spike_counter.sv */
`timescale 1ns/1ps
`include "cn_node_defs.svh"

module spike_counter (
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic              i_tick,    // window boundary
    input  logic              i_spike,
    output logic [`CN_DW-1:0] o_count    // count of the last full window
);

    logic [`CN_DW-1:0] win_cnt;  // running count of the open window
    logic [`CN_DW-1:0] count_q;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            win_cnt <= '0;
            count_q <= '0;
        end else if (i_tick) begin
            count_q <= win_cnt;                    // publish closed window
            win_cnt <= {{(`CN_DW-1){1'b0}}, i_spike};  // spike on tick opens the new one
        end else if (i_spike) begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    assign o_count = count_q;

endmodule

/* rtl/tick_gen.sv */
`timescale 1ns/1ps
`include "cn_node_defs.svh"

module tick_gen import cn_node_pkg::*; (
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic [`CN_DW-1:0] i_div,   // clocks per step minus one
    output tick_t             o_tick
);

    localparam int SW = $clog2(`CN_STEPS);

    logic [`CN_DW-1:0] cyc_cnt;
    logic [SW-1:0]     step_cnt;
    logic              step_hit;

    assign step_hit = (cyc_cnt >= i_div);  // >= so a lowered div does not run the count away

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cyc_cnt  <= '0;
            step_cnt <= '0;
        end else if (step_hit) begin
            cyc_cnt  <= '0;
            step_cnt <= step_cnt + 1'b1;  // wraps every CN_STEPS steps
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    assign o_tick.step = step_hit;
    assign o_tick.tick = step_hit && (step_cnt == SW'(`CN_STEPS - 1));

    // a tick rides on a step and is never followed by another tick
    a_tick_on_step: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_tick.tick |-> o_tick.step ##1 !o_tick.tick);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the cn_node testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f cn_node_top.f --top-module tb_cn_node \
    --Mdir obj_dir -o tb_cn_node
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cn_node > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

/* synapse/synapse.sv */
`timescale 1ns/1ps
`include "cn_node_defs.svh"

module synapse import cn_node_pkg::*; (
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic              i_step,
    input  logic              i_spike_pre,   // presynaptic spike, any cycle
    input  logic              i_spike_post,  // neuron spike, one cycle after a step
    input  syn_params_t       i_params,
    output logic [`CN_DW-1:0] o_each_i       // gained current, low word
);

    logic                     pre_lat;
    logic                     post_lat;
    logic                     pre_now;
    logic                     post_now;
    logic [7:0]               pre_hist;   // pre spikes of the last 8 steps
    logic [7:0]               post_hist;
    logic [`CN_DW-1:0]        w_q;
    logic [`CN_DW:0]          w_add;
    logic [`CN_DW-1:0]        w_pot;
    logic [`CN_DW-1:0]        w_nxt;
    logic signed [`CN_DW-1:0] cur_q;
    logic signed [`CN_DW-1:0] cur_half;
    logic signed [`CN_DW-1:0] cur_nxt;
    logic [`CN_DW-1:0]        kick;

    // spikes between steps are held so the step sees them
    assign pre_now  = pre_lat | i_spike_pre;
    assign post_now = post_lat | i_spike_post;

    always_comb begin
        w_add = {1'b0, w_q} + {1'b0, i_params.ltp};
        w_pot = w_q;
        if (pre_now && |post_hist) begin
            w_pot = w_add[`CN_DW] ? '1 : w_add[`CN_DW-1:0];  // saturate high
        end
        w_nxt = w_pot;
        if (post_now && |pre_hist) begin
            w_nxt = (w_pot > i_params.ltd) ? w_pot - i_params.ltd : '0;  // floor at zero
        end
        kick     = pre_now ? w_nxt + i_params.p_delta : '0;
        cur_half = cur_q >>> 1;  // decay by half, sign kept
        cur_nxt  = cur_half + signed'(kick);
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            pre_lat   <= 1'b0;
            post_lat  <= 1'b0;
            pre_hist  <= '0;
            post_hist <= '0;
            w_q       <= '0;
            cur_q     <= '0;
            o_each_i  <= '0;
        end else if (i_step) begin
            pre_lat   <= 1'b0;
            post_lat  <= 1'b0;
            pre_hist  <= {pre_hist[6:0], pre_now};
            post_hist <= {post_hist[6:0], post_now};
            w_q       <= w_nxt;
            cur_q     <= cur_nxt;
            o_each_i  <= cur_nxt * i_params.gain;  // low 32 bits only
        end else begin
            pre_lat  <= pre_now;
            post_lat <= post_now;
        end
    end

endmodule
